//--- paula_audio.f
+incdir+verilog
verilog/paula_audio_pkg.sv
verilog/sample_format.sv
verilog/sample_fifo.sv
verilog/sample_mixer.sv
verilog/paula_audio_top.sv
dv/paula_audio_tb.sv

//--- Makefile
# Verilator flow for paula_audio; override any variable on the command line.

VERILATOR  ?= verilator
TOP        ?= paula_audio_tb
FILELIST   ?= paula_audio.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= --lint-only
BUILD_FLAGS ?= --binary -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim build clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SRCS) verilog/paula_audio_cfg.svh
	$(VERILATOR) $(BUILD_FLAGS) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation binary is the pass or fail result
sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/paula_audio_tb.sv
// Testbench for paula_audio_top, built with Verilator --timing.
// Expected outputs in the table are worked out by hand from the format and clamp rules.
// Rows 0 to 5 share the same mute and synthesizer values for the back-pressure run.

`timescale 1ns/1ps
`include "paula_audio_cfg.svh"

module paula_audio_tb;

	localparam int SW           = `PA_SMP_W;
	localparam int N_ROWS       = 10;
	localparam int TIMEOUT      = 200; // cycles allowed per wait
	localparam int STALL_CYCLES = 20;
	localparam int DRV_DLY      = 2;   // ns after the rising edge
	localparam int N_BURST      = `PA_FIFO_DEPTH + 1; // FIFO plus mixer output register

	localparam paula_audio_pkg::fmt_e DAC = paula_audio_pkg::FMT_DAC;
	localparam paula_audio_pkg::fmt_e PWM = paula_audio_pkg::FMT_PWM;

	typedef struct packed {
		paula_audio_pkg::fmt_e    fmt;
		logic [`PA_DAC_W-1:0]     dac_l;
		logic [`PA_DAC_W-1:0]     dac_r;
		logic [`PA_PWM_W-1:0]     pwm_l;
		logic [`PA_PWM_W-1:0]     pwm_r;
		paula_audio_pkg::sample_t mt_l;
		paula_audio_pkg::sample_t mt_r;
		logic                     mute;
		paula_audio_pkg::sample_t exp_l;
		paula_audio_pkg::sample_t exp_r;
	} row_t;

	logic                     clk_sys = 1'b0;
	logic                     reset;
	logic                     smp_req;
	logic                     smp_ack;
	logic [`PA_DAC_W-1:0]     dac_l;
	logic [`PA_DAC_W-1:0]     dac_r;
	logic [`PA_PWM_W-1:0]     pwm_l;
	logic [`PA_PWM_W-1:0]     pwm_r;
	paula_audio_pkg::fmt_e    fmt;
	paula_audio_pkg::sample_t mt32_l;
	paula_audio_pkg::sample_t mt32_r;
	logic                     mt32_mute;
	logic                     out_req;
	logic                     out_ack;
	paula_audio_pkg::sample_t out_l;
	paula_audio_pkg::sample_t out_r;

	row_t rows [N_ROWS];

	paula_audio_top paula_audio_top_i (.clk_sys, .reset, .smp_req, .smp_ack, .dac_l, .dac_r,
		.pwm_l, .pwm_r, .fmt, .mt32_l, .mt32_r, .mt32_mute, .out_req, .out_ack, .out_l, .out_r);

	always #20 clk_sys = ~clk_sys; // 40 ns period

	function automatic row_t make_row(input paula_audio_pkg::fmt_e f,
		input logic [`PA_DAC_W-1:0] dl, input logic [`PA_DAC_W-1:0] dr,
		input logic [`PA_PWM_W-1:0] pl, input logic [`PA_PWM_W-1:0] pr,
		input paula_audio_pkg::sample_t ml, input paula_audio_pkg::sample_t mr,
		input logic mute, input paula_audio_pkg::sample_t el,
		input paula_audio_pkg::sample_t er);
		row_t r;
		r.fmt   = f;
		r.dac_l = dl;
		r.dac_r = dr;
		r.pwm_l = pl;
		r.pwm_r = pr;
		r.mt_l  = ml;
		r.mt_r  = mr;
		r.mute  = mute;
		r.exp_l = el;
		r.exp_r = er;
		return r;
	endfunction

	// columns: fmt, dac l/r, pwm l/r, mt32 l/r, mute, expected out l/r
	task automatic load_rows();
		rows[0] = make_row(DAC, 15'h1234, 15'h4abc, 9'h000, 9'h000,
			16'h1111, 16'heeee, 1'b1, 16'h2468, 16'h9578); // negative right sample
		rows[1] = make_row(DAC, 15'h7fff, 15'h3fff, 9'h0a5, 9'h1c3,
			16'h1111, 16'heeee, 1'b1, 16'hfffe, 16'h7ffe);
		rows[2] = make_row(PWM, 15'h0555, 15'h2aaa, 9'h0a5, 9'h1c3,
			16'h1111, 16'heeee, 1'b1, 16'h5280, 16'he180);
		rows[3] = make_row(PWM, 15'h0000, 15'h0000, 9'h100, 9'h0ff,
			16'h1111, 16'heeee, 1'b1, 16'h8000, 16'h7f80);
		rows[4] = make_row(DAC, 15'h0000, 15'h4000, 9'h000, 9'h000,
			16'h1111, 16'heeee, 1'b1, 16'h0000, 16'h8000);
		rows[5] = make_row(PWM, 15'h0000, 15'h0000, 9'h07f, 9'h1fe,
			16'h1111, 16'heeee, 1'b1, 16'h3f80, 16'hff00);
		// synthesizer mixed in from here on
		rows[6] = make_row(DAC, 15'h3000, 15'h4000, 9'h000, 9'h000,
			16'h3000, 16'hf000, 1'b0, 16'h7fff, 16'h8000); // both clamp
		rows[7] = make_row(DAC, 15'h0100, 15'h7ff0, 9'h000, 9'h000,
			16'h0034, 16'hfff0, 1'b0, 16'h0234, 16'hffd0);
		rows[8] = make_row(PWM, 15'h0000, 15'h0000, 9'h0c0, 9'h180,
			16'h7000, 16'h8000, 1'b0, 16'h7fff, 16'h8000); // both clamp
		rows[9] = make_row(PWM, 15'h0000, 15'h0000, 9'h001, 9'h1ff,
			16'hff00, 16'h0100, 1'b0, 16'hff80, 16'h0080);
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [SW-1:0] actual,
		input logic [SW-1:0] expected);
		if (actual !== expected)
			report_failure($sformatf("error: %s is %h, expected %h", name, actual, expected));
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#DRV_DLY;
	endtask

	// data first, req one cycle later
	task automatic start_send(input int idx);
		fmt       = rows[idx].fmt;
		dac_l     = rows[idx].dac_l;
		dac_r     = rows[idx].dac_r;
		pwm_l     = rows[idx].pwm_l;
		pwm_r     = rows[idx].pwm_r;
		mt32_l    = rows[idx].mt_l;
		mt32_r    = rows[idx].mt_r;
		mt32_mute = rows[idx].mute;
		next_cycle();
		smp_req = 1'b1;
	endtask

	task automatic finish_send();
		int cnt;
		cnt = 0;
		while (smp_ack !== 1'b1) begin
			if (cnt == TIMEOUT)
				report_failure("timeout: smp_ack never rose for the pending request");
			else begin
				next_cycle();
				cnt++;
			end
		end
		smp_req = 1'b0;
		cnt = 0;
		while (smp_ack !== 1'b0) begin
			if (cnt == TIMEOUT)
				report_failure("timeout: smp_ack stayed high after smp_req dropped");
			else begin
				next_cycle();
				cnt++;
			end
		end
	endtask

	task automatic send_pair(input int idx);
		start_send(idx);
		finish_send();
	endtask

	task automatic receive_pair(input int idx);
		int cnt;
		cnt = 0;
		while (out_req !== 1'b1) begin
			if (cnt == TIMEOUT)
				report_failure($sformatf("timeout: out_req never rose for row %0d", idx));
			else begin
				next_cycle();
				cnt++;
			end
		end
		check_value($sformatf("out_l of row %0d", idx), out_l, rows[idx].exp_l);
		check_value($sformatf("out_r of row %0d", idx), out_r, rows[idx].exp_r);
		out_ack = 1'b1;
		cnt = 0;
		while (out_req !== 1'b0) begin
			if (cnt == TIMEOUT)
				report_failure($sformatf("timeout: out_req stayed high after ack, row %0d", idx));
			else begin
				next_cycle();
				cnt++;
			end
		end
		out_ack = 1'b0;
	endtask

	initial begin
		reset     = 1'b1;
		smp_req   = 1'b0;
		dac_l     = '0;
		dac_r     = '0;
		pwm_l     = '0;
		pwm_r     = '0;
		fmt       = DAC;
		mt32_l    = '0;
		mt32_r    = '0;
		mt32_mute = 1'b1;
		out_ack   = 1'b0;
		load_rows();

		repeat (2) @(posedge clk_sys);
		#DRV_DLY;
		reset = 1'b0;

		// idle state right after reset
		check_value("smp_ack", SW'(smp_ack), '0);
		check_value("out_req", SW'(out_req), '0);
		check_value("out_l", out_l, '0);
		check_value("out_r", out_r, '0);

		// one pair in flight at a time
		for (int i = 0; i < N_ROWS; i++) begin
			send_pair(i);
			receive_pair(i);
		end

		// sink stalls, mixer register and FIFO fill up
		for (int i = 0; i < N_BURST; i++)
			send_pair(i);
		start_send(N_BURST);
		for (int c = 0; c < STALL_CYCLES; c++) begin
			next_cycle();
			check_value("smp_ack while stalled", SW'(smp_ack), '0);
		end

		// draining one pair frees a slot for the held request
		receive_pair(0);
		finish_send();
		for (int i = 1; i <= N_BURST; i++)
			receive_pair(i);

		$display("TEST OK");
		$finish;
	end

endmodule

//--- verilog/paula_audio_top.sv
// Stereo audio stage: format, buffer, mix with the synthesizer pair.
// Four-phase req/ack on both sides, single clock clk_sys.
// Up to PA_FIFO_DEPTH+1 pairs are accepted while the sink stalls.

`timescale 1ns/1ps
`include "paula_audio_cfg.svh"

module paula_audio_top (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     smp_req,
	output logic                     smp_ack,
	input  logic [`PA_DAC_W-1:0]     dac_l,
	input  logic [`PA_DAC_W-1:0]     dac_r,
	input  logic [`PA_PWM_W-1:0]     pwm_l,
	input  logic [`PA_PWM_W-1:0]     pwm_r,
	input  paula_audio_pkg::fmt_e    fmt,
	input  paula_audio_pkg::sample_t mt32_l,
	input  paula_audio_pkg::sample_t mt32_r,
	input  logic                     mt32_mute,
	output logic                     out_req,
	input  logic                     out_ack,
	output paula_audio_pkg::sample_t out_l,
	output paula_audio_pkg::sample_t out_r
);

	// formatter to FIFO
	logic                     push;
	paula_audio_pkg::sample_t push_l;
	paula_audio_pkg::sample_t push_r;
	logic                     full;

	// FIFO to mixer
	logic                     pop;
	paula_audio_pkg::sample_t pop_l;
	paula_audio_pkg::sample_t pop_r;
	logic                     empty;

	sample_format sample_format_i (.clk_sys, .reset, .smp_req, .smp_ack, .dac_l, .dac_r,
		.pwm_l, .pwm_r, .fmt, .full, .push, .push_l, .push_r);

	sample_fifo sample_fifo_i (.clk_sys, .reset, .push, .push_l, .push_r, .pop,
		.pop_l, .pop_r, .full, .empty);

	sample_mixer sample_mixer_i (.clk_sys, .reset, .pop_l, .pop_r, .empty, .pop,
		.mt32_l, .mt32_r, .mt32_mute, .out_req, .out_ack, .out_l, .out_r);

endmodule

//--- verilog/sample_mixer.sv
// Output side of the audio path. Pops one pair, adds the synthesizer pair and clamps.
// mt32 inputs are sampled at the pop and must be held while pairs are in flight.
// out_l/out_r stay put while out_req is high.

`timescale 1ns/1ps
`include "paula_audio_cfg.svh"

module sample_mixer (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  paula_audio_pkg::sample_t pop_l,
	input  paula_audio_pkg::sample_t pop_r,
	input  logic                     empty,
	output logic                     pop,
	input  paula_audio_pkg::sample_t mt32_l,
	input  paula_audio_pkg::sample_t mt32_r,
	input  logic                     mt32_mute,
	output logic                     out_req,
	input  logic                     out_ack,
	output paula_audio_pkg::sample_t out_l,
	output paula_audio_pkg::sample_t out_r
);

	paula_audio_pkg::hs_state_e state;
	paula_audio_pkg::sample_t   syn_l;
	paula_audio_pkg::sample_t   syn_r;
	logic signed [`PA_SMP_W:0]  sum_l; // one bit of headroom
	logic signed [`PA_SMP_W:0]  sum_r;

	// top two bits disagree means the sum left the 16 bit range
	function automatic paula_audio_pkg::sample_t clamp(input logic signed [`PA_SMP_W:0] s);
		if (s[`PA_SMP_W] != s[`PA_SMP_W-1])
			return {s[`PA_SMP_W], {(`PA_SMP_W-1){~s[`PA_SMP_W]}}};
		return s[`PA_SMP_W-1:0];
	endfunction

	assign syn_l = mt32_mute ? '0 : mt32_l;
	assign syn_r = mt32_mute ? '0 : mt32_r;
	assign sum_l = {pop_l[`PA_SMP_W-1], pop_l} + {syn_l[`PA_SMP_W-1], syn_l};
	assign sum_r = {pop_r[`PA_SMP_W-1], pop_r} + {syn_r[`PA_SMP_W-1], syn_r};

	assign pop = (state == paula_audio_pkg::HS_IDLE) && !empty;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state <= paula_audio_pkg::HS_IDLE;
			out_l <= '0;
			out_r <= '0;
		end else begin
			case (state)
				paula_audio_pkg::HS_IDLE: begin
					if (pop) begin
						out_l <= clamp(sum_l);
						out_r <= clamp(sum_r);
						state <= paula_audio_pkg::HS_HOLD; // req up next cycle
					end
				end
				paula_audio_pkg::HS_HOLD: begin
					if (out_ack)
						state <= paula_audio_pkg::HS_RELEASE; // drop req
				end
				paula_audio_pkg::HS_RELEASE: begin
					if (!out_ack)
						state <= paula_audio_pkg::HS_IDLE;
				end
				default: state <= paula_audio_pkg::HS_IDLE;
			endcase
		end
	end

	assign out_req = (state == paula_audio_pkg::HS_HOLD);

	// sink acks only a pending request
	a_ack_while_req: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(out_ack) |-> out_req)
		else $error("out_ack rose while no out_req was pending");

endmodule

//--- verilog/sample_fifo.sv
// Register FIFO of stereo pairs, PA_FIFO_DEPTH entries.
// Oldest pair shows on pop_l/pop_r without a read cycle.
// Callers must not push when full or pop when empty.

`timescale 1ns/1ps
`include "paula_audio_cfg.svh"

module sample_fifo (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     push,
	input  paula_audio_pkg::sample_t push_l,
	input  paula_audio_pkg::sample_t push_r,
	input  logic                     pop,
	output paula_audio_pkg::sample_t pop_l,
	output paula_audio_pkg::sample_t pop_r,
	output logic                     full,
	output logic                     empty
);

	paula_audio_pkg::sample_t mem_l [`PA_FIFO_DEPTH];
	paula_audio_pkg::sample_t mem_r [`PA_FIFO_DEPTH];

	logic [`PA_FIFO_AW-1:0] wr_ptr;
	logic [`PA_FIFO_AW-1:0] rd_ptr;
	logic [`PA_FIFO_AW:0]   count; // one extra bit to tell full from empty

	always_ff @(posedge clk_sys) begin
		if (push) begin
			mem_l[wr_ptr] <= push_l;
			mem_r[wr_ptr] <= push_r;
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	assign pop_l = mem_l[rd_ptr];
	assign pop_r = mem_r[rd_ptr];
	assign full  = (count == (`PA_FIFO_AW+1)'(`PA_FIFO_DEPTH));
	assign empty = (count == '0);

	a_no_push_full: assert property (@(posedge clk_sys) disable iff (reset) push |-> !full)
		else $error("push while FIFO full");
	a_no_pop_empty: assert property (@(posedge clk_sys) disable iff (reset) pop |-> !empty)
		else $error("pop while FIFO empty");

endmodule

//--- verilog/sample_format.sv
// Input side of the audio path. Source holds samples and fmt stable while smp_req is high.
// One push per request. smp_ack stays low while the FIFO is full.

`timescale 1ns/1ps
`include "paula_audio_cfg.svh"

module sample_format (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     smp_req,
	output logic                     smp_ack,
	input  logic [`PA_DAC_W-1:0]     dac_l,
	input  logic [`PA_DAC_W-1:0]     dac_r,
	input  logic [`PA_PWM_W-1:0]     pwm_l,
	input  logic [`PA_PWM_W-1:0]     pwm_r,
	input  paula_audio_pkg::fmt_e    fmt,
	input  logic                     full,
	output logic                     push,
	output paula_audio_pkg::sample_t push_l,
	output paula_audio_pkg::sample_t push_r
);

	localparam int DAC_PAD = `PA_SMP_W - `PA_DAC_W;
	localparam int PWM_PAD = `PA_SMP_W - `PA_PWM_W;

	paula_audio_pkg::hs_state_e state;

	// left-justify the selected source, sign bit lands on the MSB
	always_comb begin
		if (fmt == paula_audio_pkg::FMT_PWM) begin
			push_l = paula_audio_pkg::sample_t'({pwm_l, {PWM_PAD{1'b0}}});
			push_r = paula_audio_pkg::sample_t'({pwm_r, {PWM_PAD{1'b0}}});
		end else begin
			push_l = paula_audio_pkg::sample_t'({dac_l, {DAC_PAD{1'b0}}});
			push_r = paula_audio_pkg::sample_t'({dac_r, {DAC_PAD{1'b0}}});
		end
	end

	// only place where full is honoured
	assign push = (state == paula_audio_pkg::HS_IDLE) && smp_req && !full;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state <= paula_audio_pkg::HS_IDLE;
		end else begin
			case (state)
				paula_audio_pkg::HS_IDLE: begin
					if (push)
						state <= paula_audio_pkg::HS_HOLD; // ack up next cycle
				end
				paula_audio_pkg::HS_HOLD: begin
					if (!smp_req)
						state <= paula_audio_pkg::HS_IDLE; // source let go
				end
				default: state <= paula_audio_pkg::HS_IDLE;
			endcase
		end
	end

	assign smp_ack = (state == paula_audio_pkg::HS_HOLD);

	// source may drop smp_req only once it sees smp_ack
	a_req_held_until_ack: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(smp_req) |-> smp_ack)
		else $error("smp_req dropped before smp_ack was raised");

endmodule

//--- verilog/paula_audio_pkg.sv
// Shared types for the audio path.
// Sample width comes from the config header.

`include "paula_audio_cfg.svh"

package paula_audio_pkg;

	typedef logic signed [`PA_SMP_W-1:0] sample_t; // one channel

	// sample source select
	typedef enum logic {
		FMT_DAC, // 15 bit DAC sample
		FMT_PWM  // 9 bit PWM volume sample
	} fmt_e;

	typedef enum logic [1:0] {
		HS_IDLE,
		HS_HOLD,    // ack or req is up
		HS_RELEASE  // partner still has its signal up
	} hs_state_e;

endpackage

//--- verilog/paula_audio_cfg.svh
// Widths and FIFO depth for the audio path. Everything runs on one clock.
// PA_FIFO_DEPTH must be a power of two and match PA_FIFO_AW.
// DAC and PWM widths must stay below PA_SMP_W.

`ifndef PAULA_AUDIO_CFG_SVH
`define PAULA_AUDIO_CFG_SVH

// signed output and mix width
`define PA_SMP_W 16

// raw sample widths from the custom chip
`define PA_DAC_W 15
`define PA_PWM_W 9

// stereo pairs held in the FIFO
`define PA_FIFO_DEPTH 4
`define PA_FIFO_AW 2

`endif
